// ==== files.f ====
logic/ctrl_pkg.sv
logic/cmd_rx_buffer.sv
logic/cmd_dispatch.sv
logic/control_cmd_watchdog.sv
logic/ctrl_regs.sv
logic/ctrl_top.sv
test/ctrl_tb.sv

// ==== Makefile ====
# Verilator build of the command front end testbench.
# The run target fails when the simulation ends in $fatal.

SRCS := $(shell cat files.f)
BIN := obj_dir/Vctrl_tb

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module ctrl_tb

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== test/ctrl_tb.sv ====
/* Testbench for the command front end. The host model spends one receive credit per byte
   and grants one transmit credit per read, so reads complete one at a time. */
`timescale 1ns/1ns

module ctrl_tb
    import ctrl_pkg::*;
();
    localparam int RX_DEPTH = 8;
    localparam int WD_TICKS = 200;

    logic clk = 1'b0;
    logic reset;
    logic rx_valid;
    logic [7:0] rx_data;
    logic rx_credit;
    logic tx_valid;
    logic [7:0] tx_data;
    logic tx_credit;
    logic sys_reset;

    int bytes_sent;
    int credits_back;
    int tx_granted;
    int tx_used;
    int cmd_count;
    int cycle_count;
    int pulse_count;
    int last_pulse;
    int window_start;
    logic quiet_expected;
    logic period_check;
    logic [31:0] rng;
    logic [7:0] scratch_model;
    logic [7:0] expected_rd;
    logic [7:0] exp_q[$];

    ctrl_top #(
        .RX_DEPTH(RX_DEPTH),
        .WD_TICKS(WD_TICKS)
    ) ctrl_top_i (
        .clk(clk),
        .reset(reset),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_credit(rx_credit),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .tx_credit(tx_credit),
        .sys_reset(sys_reset)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Host side bookkeeping of credits, responses and reset pulses.
    always @(posedge clk) begin
        if (reset) begin
            credits_back <= 0;
            tx_granted <= 0;
            tx_used <= 0;
            cycle_count <= 0;
            pulse_count <= 0;
            last_pulse <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (rx_credit) begin
                credits_back <= credits_back + 1;
            end
            if (tx_credit) begin
                tx_granted <= tx_granted + 1;
            end
            if (tx_valid) begin
                tx_used <= tx_used + 1;
            end
            if (sys_reset) begin
                pulse_count <= pulse_count + 1;
                last_pulse <= cycle_count;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && tx_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("A read response arrived while no read was outstanding.");
            end else begin
                expected_rd = exp_q.pop_front();
                assert (tx_data == expected_rd)
                else fail_run($sformatf("ERR %0t: read data 0x%02h, expected 0x%02h",
                                        $time, tx_data, expected_rd));
            end
        end
    end

    a_rx_credit_return: assert property (@(posedge clk) disable iff (reset)
        credits_back <= bytes_sent)
    else fail_run($sformatf("ERR %0t: %0d credits returned for %0d bytes",
                            $time, credits_back, bytes_sent));

    a_rx_host_credit: assert property (@(posedge clk) disable iff (reset)
        bytes_sent <= RX_DEPTH + credits_back)
    else fail_run($sformatf("ERR %0t: host credit count below zero", $time));

    a_tx_credit: assert property (@(posedge clk) disable iff (reset)
        tx_valid |-> tx_used < tx_granted)
    else fail_run($sformatf("ERR %0t: tx_valid without a granted credit", $time));

    a_reset_width: assert property (@(posedge clk) disable iff (reset)
        sys_reset |=> !sys_reset)
    else fail_run($sformatf("ERR %0t: sys_reset high for more than one cycle", $time));

    a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
        quiet_expected |-> !sys_reset)
    else fail_run($sformatf("ERR %0t: sys_reset pulsed while it should stay low", $time));

    a_reset_period: assert property (@(posedge clk) disable iff (reset)
        (sys_reset && period_check && pulse_count > window_start)
        |-> (cycle_count - last_pulse == WD_TICKS + 1))
    else fail_run($sformatf("ERR %0t: reset pulse spacing %0d, expected %0d",
                            $time, cycle_count - last_pulse, WD_TICKS + 1));

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int waited;
        waited = 0;
        while (bytes_sent >= RX_DEPTH + credits_back) begin
            if (waited >= 500) fail_run("The host ran out of receive credits and none came back.");
            else begin
                wait_cycles(1);
                waited++;
            end
        end
        rx_valid = 1'b1;
        rx_data = b;
        bytes_sent++;
        wait_cycles(1);
        rx_valid = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [7:0] value);
        cmd_count++;
        send_byte(OP_WRITE);
        send_byte(8'(addr));
        send_byte(value);
    endtask

    task automatic issue_read(input reg_addr_e addr, input logic [7:0] value);
        cmd_count++;
        exp_q.push_back(value);
        send_byte(OP_READ);
        send_byte(8'(addr));
    endtask

    // Grants one transmit credit after a gap and waits for the response it releases.
    task automatic collect_response(input int gap);
        int target;
        int waited;
        target = tx_used + 1;
        waited = 0;
        wait_cycles(gap);
        tx_credit = 1'b1;
        wait_cycles(1);
        tx_credit = 1'b0;
        while (tx_used < target) begin
            if (waited >= 50) fail_run("No read response arrived after a credit was granted.");
            else begin
                wait_cycles(1);
                waited++;
            end
        end
    endtask

    task automatic read_check(input reg_addr_e addr, input logic [7:0] value);
        int gap;
        issue_read(addr, value);
        rng = lcg_step(rng);
        gap = {29'd0, rng[18:16]};
        collect_response(gap);
    endtask

    task automatic send_kick(input logic [WD_SIG_BITS-1:0] sig);
        int i;
        cmd_count++;
        send_byte(OP_KICK);
        for (i = WD_SIG_BITS / 8 - 1; i >= 0; i--) begin
            send_byte(sig[8*i +: 8]);
        end
    endtask

    // Waits until every byte sent has left the receive buffer.
    task automatic drain();
        int waited;
        waited = 0;
        while (credits_back != bytes_sent) begin
            if (waited >= 200) fail_run("The receive buffer did not drain.");
            else begin
                wait_cycles(1);
                waited++;
            end
        end
        wait_cycles(2);
    endtask

    task automatic wait_pulses(input int n);
        int target;
        int waited;
        target = pulse_count + n;
        waited = 0;
        while (pulse_count < target) begin
            if (waited >= (n + 1) * (WD_TICKS + 1)) fail_run("An expected reset pulse never came.");
            else begin
                wait_cycles(1);
                waited++;
            end
        end
    endtask

    task automatic check_scratch_round_trip();
        int i;
        for (i = 0; i < 6; i++) begin
            rng = lcg_step(rng);
            scratch_model = rng[23:16];
            write_reg(REG_SCRATCH, scratch_model);
            read_check(REG_SCRATCH, scratch_model);
        end
        write_reg(REG_CTRL, 8'hFE);
        read_check(REG_CTRL, 8'h00);
    endtask

    // A read without credit holds the dispatcher, so the write behind it stays buffered.
    task automatic check_tx_back_pressure();
        int used_before;
        logic [7:0] next_value;
        used_before = tx_used;
        rng = lcg_step(rng);
        next_value = rng[23:16];
        issue_read(REG_SCRATCH, scratch_model);
        write_reg(REG_SCRATCH, next_value);
        wait_cycles(30);
        assert (tx_used == used_before && bytes_sent - credits_back == 3)
        else fail_run($sformatf("ERR %0t: stalled read left %0d bytes held, expected 3",
                                $time, bytes_sent - credits_back));
        collect_response(0);
        scratch_model = next_value;
        read_check(REG_SCRATCH, scratch_model);
    endtask

    task automatic check_kicks();
        int start;
        int tries;
        write_reg(REG_CTRL, 8'h01);
        drain();
        quiet_expected = 1'b1;
        repeat (12) begin
            send_kick(WD_SIG_PATTERN);
            wait_cycles(WD_TICKS / 4);
        end
        quiet_expected = 1'b0;
        start = pulse_count;
        tries = 0;
        while (pulse_count == start && tries < 8) begin
            send_kick(WD_SIG_PATTERN ^ 32'h0000_0001);
            wait_cycles(WD_TICKS / 4);
            tries++;
        end
        assert (pulse_count > start)
        else fail_run($sformatf("ERR %0t: wrong kicks prevented the reset pulse", $time));
    endtask

    task automatic check_timeout_pulses();
        window_start = pulse_count;
        period_check = 1'b1;
        read_check(REG_CTRL, 8'h01);
        wait_pulses(3);
        period_check = 1'b0;
        write_reg(REG_CTRL, 8'h00);
        drain();
        read_check(REG_RESETS, 8'(pulse_count));
    endtask

    task automatic check_bad_opcodes();
        int n;
        logic [7:0] b;
        for (n = 0; n < 5; n++) begin
            b = OP_KICK;
            while (b == OP_KICK || b == OP_WRITE || b == OP_READ) begin
                rng = lcg_step(rng);
                b = rng[23:16];
            end
            cmd_count++;
            send_byte(b);
        end
        read_check(REG_BAD_OPS, 8'd5);
        scratch_model = 8'h3C;
        write_reg(REG_SCRATCH, scratch_model);
        read_check(REG_SCRATCH, scratch_model);
    endtask

    initial begin : run_limit
        int elapsed;
        elapsed = 0;
        while (elapsed < 20 * WD_TICKS + 200 * cmd_count) begin
            @(posedge clk);
            elapsed++;
        end
        fail_run($sformatf("The run timed out after %0d cycles.", elapsed));
    end

    initial begin
        reset = 1'b1;
        rx_valid = 1'b0;
        rx_data = 8'd0;
        tx_credit = 1'b0;
        quiet_expected = 1'b0;
        period_check = 1'b0;
        rng = 32'h7fd6;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_cycles(2);
        quiet_expected = 1'b1;
        wait_cycles(3 * WD_TICKS);
        quiet_expected = 1'b0;
        check_scratch_round_trip();
        check_tx_back_pressure();
        check_kicks();
        check_timeout_pulses();
        check_bad_opcodes();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== logic/ctrl_top.sv ====
/* Command front end top level. The host starts with RX_DEPTH receive credits and the
   device with no transmit credits; RX_DEPTH must be a power of two. */
`timescale 1ns/1ns

module ctrl_top
    import ctrl_pkg::*;
#(
    parameter int unsigned RX_DEPTH = 8,
    parameter int unsigned WD_TICKS = 200,
    parameter int unsigned TX_CREDIT_MAX = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       rx_credit,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    input  logic       tx_credit,
    output logic       sys_reset
);
    logic head_valid;
    logic [7:0] head_data;
    logic pop;
    logic [7:0] wd_data;
    logic wd_enable;
    logic wd_done;
    logic wd_arm;
    logic req_valid;
    reg_req_t req;
    logic bad_op;
    logic [7:0] rdata;

    cmd_rx_buffer #(
        .RX_DEPTH(RX_DEPTH)
    ) cmd_rx_buffer_i (
        .clk(clk),
        .reset(reset),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .pop(pop),
        .head_valid(head_valid),
        .head_data(head_data),
        .rx_credit(rx_credit)
    );

    cmd_dispatch #(
        .TX_CREDIT_MAX(TX_CREDIT_MAX)
    ) cmd_dispatch_i (
        .clk(clk),
        .reset(reset),
        .head_valid(head_valid),
        .head_data(head_data),
        .wd_done(wd_done),
        .rdata(rdata),
        .tx_credit(tx_credit),
        .pop(pop),
        .wd_data(wd_data),
        .wd_enable(wd_enable),
        .req_valid(req_valid),
        .req(req),
        .bad_op(bad_op),
        .tx_valid(tx_valid),
        .tx_data(tx_data)
    );

    control_cmd_watchdog #(
        .WD_TICKS(WD_TICKS)
    ) control_cmd_watchdog_i (
        .clk(clk),
        .reset(reset),
        .data_in(wd_data),
        .enable(wd_enable),
        .wd_arm(wd_arm),
        .sys_reset(sys_reset),
        .done(wd_done)
    );

    ctrl_regs ctrl_regs_i (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .bad_op(bad_op),
        .sys_reset(sys_reset),
        .rdata(rdata),
        .wd_arm(wd_arm)
    );

endmodule

// ==== logic/ctrl_regs.sv ====
/* Control and status registers. Only bit 0 of REG_CTRL is stored, and the two event
   counters saturate at 255 and ignore writes. */
`timescale 1ns/1ns

module ctrl_regs
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  reg_req_t   req,
    input  logic       bad_op,
    input  logic       sys_reset,
    output logic [7:0] rdata,
    output logic       wd_arm
);
    logic arm;
    logic [7:0] scratch;
    logic [7:0] bad_ops;
    logic [7:0] resets;
    logic wr_en;

    assign wr_en = req_valid && req.write;
    assign wd_arm = arm;

    always_ff @(posedge clk) begin
        if (reset) begin
            arm <= 1'b0;
        end else if (wr_en && req.addr == REG_CTRL) begin
            arm <= req.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && req.addr == REG_SCRATCH) begin
            scratch <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bad_ops <= '0;
            resets <= '0;
        end else begin
            if (bad_op && bad_ops != 8'hFF) begin
                bad_ops <= bad_ops + 1'b1;
            end
            if (sys_reset && resets != 8'hFF) begin
                resets <= resets + 1'b1;
            end
        end
    end

    // Read data follows the request address in the same cycle.
    always_comb begin
        case (req.addr)
            REG_CTRL: rdata = {7'd0, arm};
            REG_SCRATCH: rdata = scratch;
            REG_BAD_OPS: rdata = bad_ops;
            REG_RESETS: rdata = resets;
            default: rdata = 8'd0;
        endcase
    end

endmodule

// ==== logic/control_cmd_watchdog.sv ====
/* Watchdog fed by multi-byte kick signatures. WD_TICKS must not be a power of two, and
   the counter holds its load value while wd_arm is low. */
`timescale 1ns/1ns

module control_cmd_watchdog
    import ctrl_pkg::*;
#(
    parameter int unsigned WD_TICKS = 200
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       enable,
    input  logic       wd_arm,
    output logic       sys_reset,
    output logic       done
);
    localparam int unsigned SIG_BYTES = WD_SIG_BITS / 8;
    localparam int unsigned BYTE_CNT_W = (SIG_BYTES > 1) ? $clog2(SIG_BYTES) : 1;
    localparam int unsigned TICK_W = $clog2(WD_TICKS);
    localparam logic [TICK_W-1:0] TICK_LOAD = TICK_W'(WD_TICKS);
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(SIG_BYTES - 1);

    logic [WD_SIG_BITS-1:0] cache;
    logic [WD_SIG_BITS-1:0] cache_next;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [TICK_W-1:0] counter;
    logic take;
    logic match;

    // Bytes are ignored during the cycle that done is high.
    assign take = enable && !done;
    assign cache_next = (cache << 8) | WD_SIG_BITS'(data_in);
    assign match = take && (cache_next == WD_SIG_PATTERN);

    always_ff @(posedge clk) begin
        if (reset) begin
            cache <= '0;
            byte_cnt <= '0;
            done <= 1'b0;
        end else if (done) begin
            cache <= '0;
            byte_cnt <= '0;
            done <= 1'b0;
        end else if (take) begin
            cache <= cache_next;
            if (byte_cnt == LAST_BYTE) begin
                done <= 1'b1;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // The counter reloads on a match, on timeout, and whenever the watchdog is disarmed.
    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= TICK_LOAD;
            sys_reset <= 1'b0;
        end else begin
            sys_reset <= (counter == '0);
            if (!wd_arm || match || counter == '0) begin
                counter <= TICK_LOAD;
            end else begin
                counter <= counter - 1'b1;
            end
        end
    end

endmodule

// ==== logic/cmd_dispatch.sv ====
/* Command decoder between the receive buffer, watchdog and registers. The host must not
   grant more than TX_CREDIT_MAX transmit credits ahead of use; extra grants are lost. */
`timescale 1ns/1ns

module cmd_dispatch
    import ctrl_pkg::*;
#(
    parameter int unsigned TX_CREDIT_MAX = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       head_valid,
    input  logic [7:0] head_data,
    input  logic       wd_done,
    input  logic [7:0] rdata,
    input  logic       tx_credit,
    output logic       pop,
    output logic [7:0] wd_data,
    output logic       wd_enable,
    output logic       req_valid,
    output reg_req_t   req,
    output logic       bad_op,
    output logic       tx_valid,
    output logic [7:0] tx_data
);
    localparam int unsigned CREDIT_W = $clog2(TX_CREDIT_MAX + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(TX_CREDIT_MAX);

    dispatch_state_e state;
    dispatch_state_e state_next;
    reg_addr_e wr_addr;
    logic [7:0] rd_data;
    logic [CREDIT_W-1:0] credits;

    assign wd_data = head_data;
    assign tx_data = rd_data;

    assign req.write = (state == ST_WR_DATA);
    assign req.addr = (state == ST_WR_DATA) ? wr_addr : reg_addr_e'(head_data[1:0]);
    assign req.wdata = head_data;

    always_comb begin
        state_next = state;
        pop = 1'b0;
        wd_enable = 1'b0;
        req_valid = 1'b0;
        bad_op = 1'b0;
        tx_valid = 1'b0;
        case (state)
            ST_OPCODE: begin
                pop = head_valid;
                if (head_valid) begin
                    case (cmd_op_e'(head_data))
                        OP_KICK: state_next = ST_KICK;
                        OP_WRITE: state_next = ST_WR_ADDR;
                        OP_READ: state_next = ST_RD_ADDR;
                        default: bad_op = 1'b1;
                    endcase
                end
            end
            ST_KICK: begin
                // The watchdog alone decides when a signature is complete.
                if (wd_done) begin
                    state_next = ST_OPCODE;
                end else begin
                    pop = head_valid;
                    wd_enable = head_valid;
                end
            end
            ST_WR_ADDR: begin
                pop = head_valid;
                if (head_valid) begin
                    state_next = ST_WR_DATA;
                end
            end
            ST_WR_DATA: begin
                pop = head_valid;
                req_valid = head_valid;
                if (head_valid) begin
                    state_next = ST_OPCODE;
                end
            end
            ST_RD_ADDR: begin
                pop = head_valid;
                req_valid = head_valid;
                if (head_valid) begin
                    state_next = ST_RD_SEND;
                end
            end
            ST_RD_SEND: begin
                // Nothing is popped while the response waits for a credit.
                if (credits != '0) begin
                    tx_valid = 1'b1;
                    state_next = ST_OPCODE;
                end
            end
            default: state_next = ST_OPCODE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_OPCODE;
            credits <= '0;
        end else begin
            state <= state_next;
            if (tx_credit && !tx_valid && credits != CREDIT_MAX) begin
                credits <= credits + 1'b1;
            end else if (tx_valid && !tx_credit) begin
                credits <= credits - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WR_ADDR && head_valid) begin
            wr_addr <= reg_addr_e'(head_data[1:0]);
        end
        if (state == ST_RD_ADDR && head_valid) begin
            rd_data <= rdata;
        end
    end

endmodule

// ==== logic/cmd_rx_buffer.sv ====
/* Host byte FIFO with credit return. The host must never send more bytes than it holds
   credits for, so the buffer has no full flag and drops nothing on its own. */
`timescale 1ns/1ns

module cmd_rx_buffer #(
    parameter int unsigned RX_DEPTH = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    input  logic       pop,
    output logic       head_valid,
    output logic [7:0] head_data,
    output logic       rx_credit
);
    localparam int unsigned PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(RX_DEPTH + 1);

    logic [7:0] mem [RX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_pop;

    assign head_valid = (count != '0);
    assign head_data = mem[rd_ptr];

    // A pop request against an empty buffer is ignored.
    assign do_pop = pop && head_valid;

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (rx_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({rx_valid, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit goes back to the host for every byte that leaves the buffer.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_credit <= 1'b0;
        end else begin
            rx_credit <= do_pop;
        end
    end

endmodule

// ==== logic/ctrl_pkg.sv ====
/* Shared constants and types of the command front end. WD_SIG_BITS must be a multiple of 8,
   and the kick signature arrives most significant byte first. */
package ctrl_pkg;

    // Kick signature that reloads the watchdog.
    localparam int unsigned WD_SIG_BITS = 32;
    localparam logic [WD_SIG_BITS-1:0] WD_SIG_PATTERN = 32'hC0DE_5AFE;

    // Command opcodes as they arrive in the first byte of each command.
    typedef enum logic [7:0] {
        OP_KICK  = 8'h4B,
        OP_WRITE = 8'h57,
        OP_READ  = 8'h52
    } cmd_op_e;

    // Register map. Only the low two bits of the address byte are decoded.
    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0,
        REG_SCRATCH = 2'd1,
        REG_BAD_OPS = 2'd2,
        REG_RESETS  = 2'd3
    } reg_addr_e;

    // Request from the dispatcher to the register block.
    typedef struct packed {
        logic      write;
        reg_addr_e addr;
        logic [7:0] wdata;
    } reg_req_t;

    // Dispatcher states.
    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_KICK,
        ST_WR_ADDR,
        ST_WR_DATA,
        ST_RD_ADDR,
        ST_RD_SEND
    } dispatch_state_e;

endpackage
